//--- dv/firTbBus.svh
`ifndef FIR_TB_BUS_SVH
`define FIR_TB_BUS_SVH

// Bus and stream helpers for firTb.
// Every helper starts 1 ns after a rising edge and returns at the same point of a later cycle.
// Handshakes are judged at the rising edge, where the ready outputs have settled.

// One AXI4-Lite write with address and data presented together.
task automatic busWrite(input logic [11:0] addr, input logic [31:0] data, input axiResp resp);
	int cnt;
	expBresp = resp;
	awaddr = addr;
	wdata = data;
	awvalid = 1'b1;
	wvalid = 1'b1;
	cnt = 0;
	@(posedge clock);
	while (!(awready && wready)) begin
		cnt++;
		if (cnt > 100) abortRun("write address and data were never accepted");
		@(posedge clock);
	end
	#1;
	awvalid = 1'b0;
	wvalid = 1'b0;
	// Bready is held high, so the response leaves at the first edge that shows it.
	cnt = 0;
	@(posedge clock);
	while (!(bvalid && bready)) begin
		cnt++;
		if (cnt > 100) abortRun("write response never arrived");
		@(posedge clock);
	end
	#1;
endtask

// One AXI4-Lite read; the assertions compare the data and the response.
task automatic busRead(input logic [11:0] addr, input logic [31:0] data, input axiResp resp);
	int cnt;
	expRdata = data;
	expRresp = resp;
	araddr = addr;
	arvalid = 1'b1;
	cnt = 0;
	@(posedge clock);
	while (!arready) begin
		cnt++;
		if (cnt > 100) abortRun("read address was never accepted");
		@(posedge clock);
	end
	#1;
	arvalid = 1'b0;
	cnt = 0;
	@(posedge clock);
	while (!(rvalid && rready)) begin
		cnt++;
		if (cnt > 100) abortRun("read data never arrived");
		@(posedge clock);
	end
	#1;
endtask

// Offer one sample and hold it until the DUT takes it.
task automatic sendSample(input logic signed [7:0] value);
	int cnt;
	sampleIn = value;
	sampleInValid = 1'b1;
	cnt = 0;
	@(posedge clock);
	while (!sampleInReady) begin
		cnt++;
		if (cnt > 200) abortRun("sample input was never accepted");
		@(posedge clock);
	end
	#1;
	sampleInValid = 1'b0;
endtask

// Wait until every expected result has been taken from the output.
task automatic drainResults();
	int cnt;
	cnt = 0;
	while (rdPtr != wrPtr || resultValid) begin
		@(posedge clock);
		#1;
		cnt++;
		if (cnt > 2000) abortRun("results stopped coming out of the filter");
	end
endtask

`endif

//--- dv/firTb.sv
`timescale 1ns/1ps

module firTb import firPkg::*;;

	localparam int taps = 16;
	localparam int dataWidth = 8;
	localparam int outWidth = 2 * dataWidth + $clog2(taps);

	logic clock, rstN;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [11:0] awaddr, araddr;
	logic [31:0] wdata, rdata;
	axiResp bresp, rresp;
	logic sampleInValid, sampleInReady, resultValid, resultReady;
	logic signed [dataWidth-1:0] sampleIn;
	logic signed [outWidth-1:0] result;

	// The bus tasks set the expected responses before each transfer.
	axiResp expBresp, expRresp;
	logic [31:0] expRdata;

	// The golden model keeps both banks, the history and a FIFO of expected results.
	logic signed [7:0] modelShadow [taps];
	logic signed [7:0] modelActive [taps];
	logic signed [7:0] modelHist [taps];
	logic signed [outWidth-1:0] expMem [256];
	int wrPtr, rdPtr;
	logic pendCommit, pendClear;
	logic randomReady;
	int seed, errors, passed, failed, testStart;

	firTop #(.taps(taps), .dataWidth(dataWidth)) dut (.*);

	always #4 clock = ~clock;

	`include "firTbBus.svh"

	task automatic abortRun(input string why);
		$display("Timeout: %s", why);
		$display("STATUS: FAIL");
		$finish;
	endtask

	task automatic endTest(input string name);
		if (errors == testStart) begin
			passed++;
			$display("test %s finished ok", name);
		end else begin
			failed++;
			$display("test %s finished with %0d errors", name, errors - testStart);
		end
		testStart = errors;
	endtask

	// The model watches the port handshakes and applies the filter rule by itself.
	always @(posedge clock) begin
		int acc;
		if (awvalid && awready && wvalid && wready) begin
			if (awaddr >= 12'h100 && awaddr < 12'h140) modelShadow[awaddr[5:2]] = wdata[7:0];
			pendCommit = awaddr == 12'h000 && wdata[1];
			pendClear = awaddr == 12'h000 && wdata[2] && !wdata[1];
		end
		if (bvalid && bready && expBresp == OKAY && pendCommit) modelActive = modelShadow;
		if (sampleInValid && sampleInReady) begin
			for (int k = taps - 1; k > 0; k--) modelHist[k] = modelHist[k-1];
			modelHist[0] = sampleIn;
			acc = 0;
			for (int k = 0; k < taps; k++) acc += modelHist[k] * modelActive[k];
			expMem[wrPtr[7:0]] <= outWidth'(acc);
			wrPtr <= wrPtr + 1;
		end
		// A clear seen on the bus zeroes the history for samples taken from the next cycle on.
		if (awvalid && awready && wvalid && wready && pendClear) begin
			for (int k = 0; k < taps; k++) modelHist[k] = '0;
		end
		if (resultValid && resultReady) rdPtr <= rdPtr + 1;
	end

	// Random back-pressure on the result stream when enabled.
	// The draw happens at the edge, apart from the stimulus draws 1 ns later.
	always @(posedge clock) begin
		logic nextReady;
		nextReady = randomReady ? $random(seed) : 1'b1;
		#1;
		resultReady = nextReady;
	end

	resultCheck: assert property (@(posedge clock) disable iff (!rstN)
		resultValid && resultReady |-> rdPtr != wrPtr && result == expMem[rdPtr[7:0]])
		else begin
			errors++;
			$display("** Error: result expected %h actual %h",
				$sampled(expMem[rdPtr[7:0]]), $sampled(result));
		end
	brespCheck: assert property (@(posedge clock) disable iff (!rstN)
		bvalid && bready |-> bresp == expBresp)
		else begin
			errors++;
			$display("** Error: bresp expected %h actual %h", $sampled(expBresp), $sampled(bresp));
		end
	rrespCheck: assert property (@(posedge clock) disable iff (!rstN)
		rvalid && rready |-> rresp == expRresp)
		else begin
			errors++;
			$display("** Error: rresp expected %h actual %h", $sampled(expRresp), $sampled(rresp));
		end
	rdataCheck: assert property (@(posedge clock) disable iff (!rstN)
		rvalid && rready |-> rdata == expRdata)
		else begin
			errors++;
			$display("** Error: rdata expected %h actual %h", $sampled(expRdata), $sampled(rdata));
		end
	stallCheck: assert property (@(posedge clock) disable iff (!rstN)
		resultValid && !resultReady |-> !sampleInReady)
		else begin
			errors++;
			$display("Input stayed ready while a held result blocked the pipeline");
		end

	initial begin
		logic [7:0] c;
		clock = 0;
		rstN = 0;
		seed = 24;
		randomReady = 0;
		resultReady = 1;
		awvalid = 0;
		wvalid = 0;
		arvalid = 0;
		awaddr = 0;
		araddr = 0;
		wdata = 0;
		bready = 1;
		rready = 1;
		sampleInValid = 0;
		sampleIn = 0;
		wrPtr = 0;
		rdPtr = 0;
		errors = 0;
		passed = 0;
		failed = 0;
		testStart = 0;
		pendCommit = 0;
		pendClear = 0;
		expBresp = OKAY;
		expRresp = OKAY;
		expRdata = 0;
		for (int k = 0; k < taps; k++) begin
			modelShadow[k] = 0;
			modelActive[k] = 0;
			modelHist[k] = 0;
		end
		repeat (4) @(posedge clock);
		#1 rstN = 1;

		// Coefficients read back sign extended, and unmapped space answers with SLVERR.
		for (int k = 0; k < taps; k++) begin
			c = 8'(k * 19 - 100);
			busWrite(12'h100 + 12'(4 * k), {24'hABCDEF, c}, OKAY);
			busRead(12'h100 + 12'(4 * k), {{24{c[7]}}, c}, OKAY);
		end
		busWrite(12'h008, 32'h1, SLVERR);
		busWrite(12'h140, 32'h5, SLVERR);
		busRead(12'h008, 32'h0, SLVERR);
		busRead(12'h140, 32'h0, SLVERR);
		endTest("coefficient registers");

		// A unit impulse walks the committed taps out in order.
		busWrite(12'h000, 32'h2, OKAY);
		busWrite(12'h000, 32'h1, OKAY);
		sendSample(8'sd1);
		for (int k = 1; k < taps; k++) sendSample(8'sd0);
		drainResults();
		// Once drained, control shows enable alone and status shows enable without busy.
		busRead(12'h000, 32'h1, OKAY);
		busRead(12'h004, 32'h1, OKAY);
		endTest("impulse response");

		// Random coefficients and a long random stream at full precision.
		busWrite(12'h000, 32'h0, OKAY);
		for (int k = 0; k < taps; k++) busWrite(12'h100 + 12'(4 * k), $random(seed), OKAY);
		busWrite(12'h000, 32'h2, OKAY);
		busWrite(12'h000, 32'h1, OKAY);
		for (int n = 0; n < 200; n++) sendSample(8'($random(seed)));
		drainResults();
		endTest("random stream");

		// Random stalls on the output must not lose or reorder results.
		randomReady = 1;
		for (int n = 0; n < 100; n++) sendSample(8'($random(seed)));
		drainResults();
		randomReady = 0;
		endTest("back-pressure");

		// A refused commit leaves the old active bank in use.
		for (int k = 0; k < taps; k++) busWrite(12'h100 + 12'(4 * k), 32'h7F, OKAY);
		busWrite(12'h000, 32'h3, SLVERR);
		busRead(12'h104, 32'h7F, OKAY);
		for (int n = 0; n < 40; n++) sendSample(8'($random(seed)));
		drainResults();
		endTest("illegal commit");

		// After a clear the older samples count as zero.
		busWrite(12'h000, 32'h5, OKAY);
		for (int n = 0; n < 40; n++) sendSample(8'($random(seed)));
		drainResults();
		endTest("history clear");

		$display("tests passed %0d failed %0d", passed, failed);
		if (failed == 0 && errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	// Hard limit on the whole run.
	initial begin
		#2ms;
		abortRun("the run exceeded its overall time limit");
	end

endmodule

//--- logic/coeffBank.sv
`timescale 1ns/1ps

module coeffBank import firPkg::*; #(
	parameter int taps = 16,
	parameter int dataWidth = 8,
	localparam int idxWidth = $clog2(taps)
) (
	input logic clock,
	input logic rstN,
	input csrCtrl ctrl,
	input logic coeffWe,
	input logic [idxWidth-1:0] coeffIndex,
	input logic [dataWidth-1:0] coeffData,
	output logic [taps*dataWidth-1:0] shadowCoeffs,
	output logic [taps*dataWidth-1:0] activeCoeffs
);

	// Both banks are flat vectors with tap k in bits k*dataWidth and up.
	// The host only ever writes the shadow bank.
	// The datapath only ever reads the active bank, so reloading never disturbs a running filter.

	// The strobe selects one tap slot and the write lands one cycle after it.
	// The register block has already checked that the index is below taps.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			shadowCoeffs <= '0;
		end else if (coeffWe) begin
			shadowCoeffs[coeffIndex*dataWidth +: dataWidth] <= coeffData;
		end
	end

	// The commit pulse copies the whole shadow bank in one cycle.
	// Taps that were not rewritten since the last commit keep their shadow value and so
	// carry over unchanged.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			activeCoeffs <= '0;
		end else if (ctrl.commit) begin
			activeCoeffs <= shadowCoeffs;
		end
	end

	// A commit never meets a shadow write in the same cycle.
	// Both come from separate bus writes, and the register block takes one write at a time
	// with a response cycle between them.

endmodule

//--- logic/firCsr.sv
`timescale 1ns/1ps

module firCsr import firPkg::*; #(
	parameter int taps = 16,
	parameter int dataWidth = 8,
	localparam int idxWidth = $clog2(taps)
) (
	input logic clock,
	input logic rstN,
	input logic awvalid,
	output logic awready,
	input logic [11:0] awaddr,
	input logic wvalid,
	output logic wready,
	input logic [31:0] wdata,
	output logic bvalid,
	input logic bready,
	output axiResp bresp,
	input logic arvalid,
	output logic arready,
	input logic [11:0] araddr,
	output logic rvalid,
	input logic rready,
	output logic [31:0] rdata,
	output axiResp rresp,
	input logic [taps*dataWidth-1:0] shadowCoeffs,
	input logic busy,
	output csrCtrl ctrl,
	output logic coeffWe,
	output logic [idxWidth-1:0] coeffIndex,
	output logic [dataWidth-1:0] coeffData
);

	// The address and data of a write are only taken together.
	// Nothing new is taken while the previous write response still waits for bready.
	logic writeAccept;
	logic readAccept;
	regWord writeWord;
	regWord readWord;
	axiResp writeResp;
	axiResp readResp;
	logic [9:0] writeOffset;
	logic [9:0] readOffset;
	logic writeIsCtrl;
	logic writeIsStatus;
	logic writeIsCoeff;
	logic readIsCoeff;
	logic commitRefused;
	logic signed [dataWidth-1:0] readCoeff;

	assign writeAccept = awvalid && wvalid && !bvalid;
	assign awready = writeAccept;
	assign wready = writeAccept;

	// A read is taken whenever no read data is waiting on the r channel.
	assign readAccept = arvalid && !rvalid;
	assign arready = readAccept;

	// Word distance from the start of the coefficient window.
	// It wraps for addresses below the window, which the range compare below excludes.
	assign writeOffset = awaddr[11:2] - coeffBaseOffset[11:2];
	assign readOffset = araddr[11:2] - coeffBaseOffset[11:2];

	assign writeIsCtrl = awaddr[11:2] == ctrlOffset[11:2];
	assign writeIsStatus = awaddr[11:2] == statusOffset[11:2];
	assign writeIsCoeff = (awaddr >= coeffBaseOffset) && (writeOffset < 10'(taps));
	assign readIsCoeff = (araddr >= coeffBaseOffset) && (readOffset < 10'(taps));

	// The write word is decoded as a control word or as coefficient data.
	assign writeWord.raw = wdata;

	// Swapping banks under a running filter would mix old and new taps inside one result.
	// So a commit is only allowed while the filter is stopped and has drained.
	assign commitRefused = writeWord.ctrl.commit && (ctrl.enable || busy);

	// The status register is read only, and a write to it is accepted and dropped.
	always_comb begin
		if (writeIsCtrl) begin
			writeResp = commitRefused ? SLVERR : OKAY;
		end else if (writeIsStatus || writeIsCoeff) begin
			writeResp = OKAY;
		end else begin
			writeResp = SLVERR;
		end
	end

	// Coefficients come back from the shadow bank, so a read shows what the next commit loads.
	assign readCoeff = shadowCoeffs[readOffset[idxWidth-1:0]*dataWidth +: dataWidth];

	// Read data mux.
	// Unmapped reads return zero with an error response.
	always_comb begin
		readWord.raw = '0;
		readResp = OKAY;
		if (araddr[11:2] == ctrlOffset[11:2]) begin
			readWord.ctrl.enable = ctrl.enable;
		end else if (araddr[11:2] == statusOffset[11:2]) begin
			// Bit 0 mirrors enable and bit 1 shows that the pipeline holds samples.
			readWord.raw[0] = ctrl.enable;
			readWord.raw[1] = busy;
		end else if (readIsCoeff) begin
			readWord.raw = 32'(readCoeff);
		end else begin
			readResp = SLVERR;
		end
	end

	// Handshake state and control outputs.
	// The commit and clear pulses last exactly one cycle after the accepting write.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			ctrl <= '0;
			coeffWe <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			ctrl.commit <= 1'b0;
			ctrl.clearHistory <= 1'b0;
			coeffWe <= 1'b0;
			if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
			if (writeAccept) begin
				bvalid <= 1'b1;
				coeffWe <= writeIsCoeff;
				if (writeIsCtrl && !commitRefused) begin
					ctrl.enable <= writeWord.ctrl.enable;
					ctrl.commit <= writeWord.ctrl.commit;
					ctrl.clearHistory <= writeWord.ctrl.clearHistory;
				end
			end
			if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
			if (readAccept) begin
				rvalid <= 1'b1;
			end
		end
	end

	// Response codes, read data and the coefficient strobe payload.
	always_ff @(posedge clock) begin
		if (writeAccept) begin
			bresp <= writeResp;
			coeffIndex <= writeOffset[idxWidth-1:0];
			coeffData <= writeWord.raw[dataWidth-1:0];
		end
		if (readAccept) begin
			rdata <= readWord.raw;
			rresp <= readResp;
		end
	end

	// The write response must wait for the master with its code unchanged.
	bHold: assert property (@(posedge clock) disable iff (!rstN)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else $error("bvalid or bresp changed before bready");

	// The bank swap must never land while a sample is still inside the datapath.
	commitIdle: assert property (@(posedge clock) disable iff (!rstN)
		ctrl.commit |-> !busy)
		else $error("commit pulse while the datapath is busy");

endmodule

//--- logic/firDatapath.sv
`timescale 1ns/1ps

module firDatapath import firPkg::*; #(
	parameter int taps = 16,
	parameter int dataWidth = 8,
	localparam int outWidth = 2 * dataWidth + $clog2(taps)
) (
	input logic clock,
	input logic rstN,
	input csrCtrl ctrl,
	input logic [taps*dataWidth-1:0] activeCoeffs,
	input logic sampleInValid,
	output logic sampleInReady,
	input logic signed [dataWidth-1:0] sampleIn,
	output logic resultValid,
	input logic resultReady,
	output logic signed [outWidth-1:0] result,
	output logic busy
);

	// The delay line keeps the taps-1 samples before the newest one, index 0 most recent.
	// The newest sample never sits in it, since it goes straight to the multipliers.
	logic signed [dataWidth-1:0] delayLine [taps-1];
	logic signed [dataWidth-1:0] window [taps];
	logic signed [dataWidth-1:0] coeffs [taps];
	logic signed [2*dataWidth-1:0] products [taps];
	logic signed [outWidth-1:0] sum;
	logic stage1Valid;
	logic advance;
	logic accept;

	// Both stages move together.
	// They can move when the output slot is empty or its result leaves this cycle.
	assign advance = !resultValid || resultReady;

	// Input is held off in the cycle of a bank swap.
	// A commit and an enable in the same write would otherwise let the first sample meet the old bank.
	assign sampleInReady = ctrl.enable && !ctrl.commit && advance;
	assign accept = sampleInValid && sampleInReady;

	// Anything in either stage counts, so a commit waits until the last result has left.
	assign busy = stage1Valid || resultValid;

	always_comb begin
		for (int k = 0; k < taps; k++) begin
			coeffs[k] = $signed(activeCoeffs[k*dataWidth +: dataWidth]);
		end
	end

	// The window is the new sample followed by the stored history.
	// Under a clear the history reads as zero, so a sample taken with the pulse already sees it.
	always_comb begin
		window[0] = sampleIn;
		for (int k = 1; k < taps; k++) begin
			window[k] = ctrl.clearHistory ? '0 : delayLine[k-1];
		end
	end

	// The history shifts only when a sample is taken.
	// Without one, a clear pulse empties the line on its own.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int k = 0; k < taps - 1; k++) begin
				delayLine[k] <= '0;
			end
		end else if (accept) begin
			for (int k = 0; k < taps - 1; k++) begin
				delayLine[k] <= window[k];
			end
		end else if (ctrl.clearHistory) begin
			for (int k = 0; k < taps - 1; k++) begin
				delayLine[k] <= '0;
			end
		end
	end

	// Stage one registers every tap product.
	// Both factors are signed, so each product is sign extended into twice the data width.
	always_ff @(posedge clock) begin
		if (accept) begin
			for (int k = 0; k < taps; k++) begin
				products[k] <= window[k] * coeffs[k];
			end
		end
	end

	// Adder tree in behavioral form.
	// The extra log2(taps) bits keep the sum exact for any coefficient set.
	always_comb begin
		sum = '0;
		for (int k = 0; k < taps; k++) begin
			sum = sum + outWidth'(products[k]);
		end
	end

	// Valid bits of both stages.
	// A stage only empties when the stage behind it can take its content.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			stage1Valid <= 1'b0;
			resultValid <= 1'b0;
		end else if (advance) begin
			stage1Valid <= accept;
			resultValid <= stage1Valid;
		end
	end

	// Stage two holds the full-width result until the consumer takes it.
	always_ff @(posedge clock) begin
		if (advance && stage1Valid) begin
			result <= sum;
		end
	end

	// A held result must not change or vanish before the consumer takes it.
	resultHold: assert property (@(posedge clock) disable iff (!rstN)
		resultValid && !resultReady |=> resultValid && $stable(result))
		else $error("result changed while stalled");

endmodule

//--- logic/firPkg.sv
package firPkg;

	// Byte offsets of the register map on the AXI4-Lite port.
	// The bus is word addressed in practice, so the low two bits are ignored by the decoder.
	localparam logic [11:0] ctrlOffset = 12'h000;
	localparam logic [11:0] statusOffset = 12'h004;

	// Coefficient k lives at coeffBaseOffset plus four times k.
	localparam logic [11:0] coeffBaseOffset = 12'h100;

	// Layout of the control register.
	// The enable bit is held, while commit and clearHistory only act in the write that sets them.
	// They always read back as zero.
	typedef struct packed {
		logic [28:0] reserved;
		logic clearHistory;
		logic commit;
		logic enable;
	} ctrlWord;

	// One bus word seen two ways.
	// A coefficient write uses the raw view, and a control write uses the ctrlWord view.
	// The register block picks the view from the address.
	typedef union packed {
		logic [31:0] raw;
		ctrlWord ctrl;
	} regWord;

	// Response codes on the b and r channels.
	// Only the two codes this slave can return are listed.
	typedef enum logic [1:0] {
		OKAY = 2'b00,
		SLVERR = 2'b10
	} axiResp;

	// Control that the register block sends to the coefficient bank and the datapath.
	// Enable is a level.
	// ClearHistory and commit are single-cycle pulses.
	typedef struct packed {
		logic enable;
		logic clearHistory;
		logic commit;
	} csrCtrl;

endpackage

//--- logic/firTop.sv
`timescale 1ns/1ps

module firTop import firPkg::*; #(
	parameter int taps = 16,
	parameter int dataWidth = 8,
	localparam int idxWidth = $clog2(taps),
	localparam int outWidth = 2 * dataWidth + $clog2(taps)
) (
	input logic clock,
	input logic rstN,
	input logic awvalid,
	output logic awready,
	input logic [11:0] awaddr,
	input logic wvalid,
	output logic wready,
	input logic [31:0] wdata,
	output logic bvalid,
	input logic bready,
	output axiResp bresp,
	input logic arvalid,
	output logic arready,
	input logic [11:0] araddr,
	output logic rvalid,
	input logic rready,
	output logic [31:0] rdata,
	output axiResp rresp,
	input logic sampleInValid,
	output logic sampleInReady,
	input logic signed [dataWidth-1:0] sampleIn,
	output logic resultValid,
	input logic resultReady,
	output logic signed [outWidth-1:0] result
);

	// Control, coefficient strobes and the two banks between the blocks.
	csrCtrl ctrl;
	logic coeffWe;
	logic [idxWidth-1:0] coeffIndex;
	logic [dataWidth-1:0] coeffData;
	logic [taps*dataWidth-1:0] shadowCoeffs;
	logic [taps*dataWidth-1:0] activeCoeffs;
	logic busy;

	// Register block on the host bus.
	firCsr #(.taps(taps), .dataWidth(dataWidth)) csr (
		.clock, .rstN,
		.awvalid, .awready, .awaddr, .wvalid, .wready, .wdata,
		.bvalid, .bready, .bresp,
		.arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
		.shadowCoeffs, .busy, .ctrl, .coeffWe, .coeffIndex, .coeffData
	);

	// Shadow and active coefficient banks.
	coeffBank #(.taps(taps), .dataWidth(dataWidth)) bank (
		.clock, .rstN, .ctrl, .coeffWe, .coeffIndex, .coeffData,
		.shadowCoeffs, .activeCoeffs
	);

	// Two-stage filter pipeline between the sample and result streams.
	firDatapath #(.taps(taps), .dataWidth(dataWidth)) datapath (
		.clock, .rstN, .ctrl, .activeCoeffs,
		.sampleInValid, .sampleInReady, .sampleIn,
		.resultValid, .resultReady, .result, .busy
	);

endmodule

//--- verilog.f
+incdir+dv
logic/firPkg.sv
logic/firCsr.sv
logic/coeffBank.sv
logic/firDatapath.sv
logic/firTop.sv
dv/firTb.sv
